//--- common/fetch_pkg.sv
// ----------------------------------------------------------------------
// Fetch package: shared widths, RISC-V opcode constants and the
// fetch controller state encoding
// ----------------------------------------------------------------------
`default_nettype none

package fetch_pkg;

  // Program counter and branch target
  typedef logic [31:0] pc_t;

  // Raw instruction word, compressed form in the low half
  typedef logic [31:0] instr_t;

  // One instruction memory location
  typedef logic [15:0] half_t;

  // Major opcode field, bits 6:0 of an uncompressed instruction
  typedef logic [6:0] opcode_t;

  // Conditional branches (BEQ, BNE, BLT, BGE, BLTU, BGEU)
  localparam opcode_t OPCODE_BRANCH = 7'b1100011;
  // Jump and link, PC relative
  localparam opcode_t OPCODE_JAL    = 7'b1101111;

  // Fetch sequence
  // READ issues the memory read, WAIT_DATA captures it,
  // OFFER holds req high, RELEASE waits for ack to fall
  typedef enum logic [1:0] {
    READ      = 2'd0,
    WAIT_DATA = 2'd1,
    OFFER     = 2'd2,
    RELEASE   = 2'd3
  } fetch_state_e;

endpackage

`default_nettype wire

//--- fetch/branch_predict.sv
// ----------------------------------------------------------------------
// Static branch predictor: jumps taken, branches taken when backward
// Purely combinational, target is PC plus the decoded offset
// ----------------------------------------------------------------------
`default_nettype none

module branch_predict (
  input  fetch_pkg::instr_t instr_i,
  input  fetch_pkg::pc_t    pc_i,
  input  logic              valid_i,
  output logic              taken_o,
  output fetch_pkg::pc_t    target_o
);
  import fetch_pkg::*;

  // Sign-extended offsets, one per instruction format
  pc_t imm_j;
  pc_t imm_b;
  pc_t imm_cj;
  pc_t imm_cb;
  pc_t offset;

  // Instruction kinds
  logic instr_j;
  logic instr_b;
  logic instr_cj;
  logic instr_cb;
  logic cond_taken;

  // J-type: imm[20|10:1|11|19:12]
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  // B-type: imm[12|10:5] in rs2 slot, imm[4:1|11] in rd slot
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};

  // CJ format, 11-bit offset scattered over bits 12:2
  assign imm_cj = {{21{instr_i[12]}}, instr_i[8], instr_i[10:9],
                   instr_i[6], instr_i[7], instr_i[2], instr_i[11],
                   instr_i[5:3], 1'b0};

  // CB format, 8-bit offset
  assign imm_cb = {{24{instr_i[12]}}, instr_i[6:5], instr_i[2],
                   instr_i[11:10], instr_i[4:3], 1'b0};

  // Uncompressed kinds by major opcode
  assign instr_b = (instr_i[6:0] == OPCODE_BRANCH);
  assign instr_j = (instr_i[6:0] == OPCODE_JAL);

  // Quadrant 1 compressed kinds
  // funct3 101 is C.J, 001 is C.JAL (RV32)
  assign instr_cj = (instr_i[1:0] == 2'b01) &&
                    ((instr_i[15:13] == 3'b101) || (instr_i[15:13] == 3'b001));
  // funct3 110 is C.BEQZ, 111 is C.BNEZ
  assign instr_cb = (instr_i[1:0] == 2'b01) &&
                    ((instr_i[15:13] == 3'b110) || (instr_i[15:13] == 3'b111));

  // Offset select, kinds never overlap since quadrant bits differ
  always_comb begin
    offset = imm_b;
    if (instr_j) begin
      offset = imm_j;
    end else if (instr_cj) begin
      offset = imm_cj;
    end else if (instr_cb) begin
      offset = imm_cb;
    end
  end

  // Backward conditional branches predicted taken
  assign cond_taken = (instr_b && imm_b[31]) || (instr_cb && imm_cb[31]);

  assign taken_o  = valid_i && (instr_j || instr_cj || cond_taken);
  assign target_o = pc_i + offset;

endmodule

`default_nettype wire

//--- fetch/fetch_ctrl.sv
// ----------------------------------------------------------------------
// Fetch controller: PC register, memory read sequencing and the
// four-phase instruction offer to the consumer
// ----------------------------------------------------------------------
`default_nettype none

module fetch_ctrl #(
  parameter int unsigned    MEM_AW  = 10,
  parameter fetch_pkg::pc_t BOOT_PC = '0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              run_i,
  input  fetch_pkg::instr_t rd_data_i,
  input  logic              instr_ack_i,
  output logic              rd_en_o,
  output logic [MEM_AW-1:0] rd_addr_o,
  output logic              instr_req_o,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::pc_t    instr_pc_o,
  output logic              instr_taken_o
);
  import fetch_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  pc_t    pc_q;
  pc_t    next_pc_q;
  pc_t    seq_pc;
  instr_t instr_q;

  // Predictor results for the instruction on offer
  logic pred_valid;
  logic pred_taken;
  pc_t  pred_target;
  logic is_compressed;

  // Read only issued while running, so a stop parks in READ
  assign rd_en_o   = (state_q == READ) && run_i;
  // Halfword index, upper PC bits dropped so fetch wraps
  assign rd_addr_o = pc_q[MEM_AW:1];

  always_comb begin
    state_d = state_q;
    case (state_q)
      READ: begin
        if (run_i) begin
          state_d = WAIT_DATA;
        end
      end
      // Memory data lands this cycle
      WAIT_DATA: state_d = OFFER;
      OFFER: begin
        if (instr_ack_i) begin
          state_d = RELEASE;
        end
      end
      RELEASE: begin
        if (!instr_ack_i) begin
          state_d = READ;
        end
      end
      default: state_d = READ;
    endcase
  end

  // Low bits other than 11 mark a 16-bit instruction
  assign is_compressed = (instr_q[1:0] != 2'b11);
  assign seq_pc        = is_compressed ? pc_q + 32'd2 : pc_q + 32'd4;

  // Prediction only meaningful while offering
  assign pred_valid = (state_q == OFFER);

  branch_predict u_branch_predict (
    .instr_i  (instr_q),
    .pc_i     (pc_q),
    .valid_i  (pred_valid),
    .taken_o  (pred_taken),
    .target_o (pred_target)
  );

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= READ;
      pc_q    <= BOOT_PC;
    end else begin
      state_q <= state_d;
      // PC moves once the consumer has released ack
      if ((state_q == RELEASE) && !instr_ack_i) begin
        pc_q <= next_pc_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == WAIT_DATA) begin
      instr_q <= rd_data_i;
    end
    // Snapshot next PC while the prediction is still valid
    if ((state_q == OFFER) && instr_ack_i) begin
      next_pc_q <= pred_taken ? pred_target : seq_pc;
    end
  end

  // Offer outputs, held stable by the registers above
  assign instr_req_o   = (state_q == OFFER);
  assign instr_o       = instr_q;
  assign instr_pc_o    = pc_q;
  assign instr_taken_o = pred_taken;

endmodule

`default_nettype wire

//--- rtl/instr_mem.sv
// ----------------------------------------------------------------------
// Instruction memory: halfword array with a four-phase load port
// and a registered 32-bit read spanning two halfwords
// ----------------------------------------------------------------------
`default_nettype none

module instr_mem #(
  parameter int unsigned MEM_AW = 10
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              load_req_i,
  input  logic [MEM_AW-1:0] load_addr_i,
  input  fetch_pkg::half_t  load_data_i,
  output logic              load_ack_o,
  input  logic              rd_en_i,
  input  logic [MEM_AW-1:0] rd_addr_i,
  output fetch_pkg::instr_t rd_data_o
);
  import fetch_pkg::*;

  half_t mem [0:(1 << MEM_AW) - 1];

  logic              ack_q;
  logic              load_wr;
  logic [MEM_AW-1:0] rd_addr_hi;
  instr_t            rd_data_q;

  // New request seen while ack still low
  assign load_wr = load_req_i && !ack_q;

  // Upper halfword, wraps at the end of memory
  assign rd_addr_hi = rd_addr_i + 1'b1;

  // Ack follows req one cycle later in both directions
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else if (load_wr) begin
      ack_q <= 1'b1;
    end else if (!load_req_i) begin
      ack_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    // Write lands on the same edge that raises ack
    if (load_wr) begin
      mem[load_addr_i] <= load_data_i;
    end
    if (rd_en_i) begin
      rd_data_q <= {mem[rd_addr_hi], mem[rd_addr_i]};
    end
  end

  assign load_ack_o = ack_q;
  assign rd_data_o  = rd_data_q;

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
// ----------------------------------------------------------------------
// Fetch front end top: instruction memory plus fetch controller
// ----------------------------------------------------------------------
`default_nettype none

module fetch_top #(
  parameter int unsigned    MEM_AW  = 10,
  parameter fetch_pkg::pc_t BOOT_PC = '0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              run_i,
  // Program load port
  input  logic              load_req_i,
  input  logic [MEM_AW-1:0] load_addr_i,
  input  fetch_pkg::half_t  load_data_i,
  output logic              load_ack_o,
  // Instruction offer port
  output logic              instr_req_o,
  output fetch_pkg::instr_t instr_o,
  output fetch_pkg::pc_t    instr_pc_o,
  output logic              instr_taken_o,
  input  logic              instr_ack_i
);
  import fetch_pkg::*;

  // Controller to memory read path
  logic              rd_en;
  logic [MEM_AW-1:0] rd_addr;
  instr_t            rd_data;

  instr_mem #(
    .MEM_AW (MEM_AW)
  ) u_instr_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_req_i  (load_req_i),
    .load_addr_i (load_addr_i),
    .load_data_i (load_data_i),
    .load_ack_o  (load_ack_o),
    .rd_en_i     (rd_en),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (rd_data)
  );

  fetch_ctrl #(
    .MEM_AW  (MEM_AW),
    .BOOT_PC (BOOT_PC)
  ) u_fetch_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .run_i         (run_i),
    .rd_data_i     (rd_data),
    .instr_ack_i   (instr_ack_i),
    .rd_en_o       (rd_en),
    .rd_addr_o     (rd_addr),
    .instr_req_o   (instr_req_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .instr_taken_o (instr_taken_o)
  );

endmodule

`default_nettype wire

//--- testbench/fetch_props.sv
// --------------------------------------------------------------------
// Fetch front end properties: offer and load handshakes and the
// predictor decode kinds, bound into the top level
// --------------------------------------------------------------------
`default_nettype none

module fetch_props (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    load_req_i,
  input logic                    load_ack_i,
  input logic                    instr_req_i,
  input logic                    instr_ack_i,
  input fetch_pkg::instr_t       instr_i,
  input fetch_pkg::pc_t          pc_i,
  input logic                    taken_i,
  input fetch_pkg::fetch_state_e state_i,
  input logic [3:0]              kinds_i
);
  import fetch_pkg::*;

  // Count of failed properties
  int fail_count = 0;

  // Offer stays up until the consumer acks
  offer_held : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      instr_req_i && !instr_ack_i |=> instr_req_i)
    else begin
      fail_count++;
      $error("Offer withdrawn before ack");
    end

  // Same offer, same data
  offer_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      instr_req_i && $past(instr_req_i) |->
      $stable(instr_i) && $stable(pc_i) && $stable(taken_i))
    else begin
      fail_count++;
      $error("Offer data changed while req high");
    end

  // JAL, BRANCH, CJ, CB never decoded together
  kinds_onehot : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (state_i == OFFER) |-> $onehot0(kinds_i))
    else begin
      fail_count++;
      $error("More than one instruction kind decoded");
    end

  // Ack only in answer to a request
  load_ack_rise : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $rose(load_ack_i) |-> $past(load_req_i))
    else begin
      fail_count++;
      $error("Load ack rose without a request");
    end

endmodule

bind fetch_top fetch_props u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .load_req_i  (load_req_i),
  .load_ack_i  (load_ack_o),
  .instr_req_i (instr_req_o),
  .instr_ack_i (instr_ack_i),
  .instr_i     (instr_o),
  .pc_i        (instr_pc_o),
  .taken_i     (instr_taken_o),
  .state_i     (u_fetch_ctrl.state_q),
  .kinds_i     ({u_fetch_ctrl.u_branch_predict.instr_j,
                 u_fetch_ctrl.u_branch_predict.instr_b,
                 u_fetch_ctrl.u_branch_predict.instr_cj,
                 u_fetch_ctrl.u_branch_predict.instr_cb})
);

`default_nettype wire

//--- testbench/tb_fetch_top.sv
// --------------------------------------------------------------------
// Fetch front end testbench: loads a random program, acks offers
// after random delays and checks each offer against a model
// --------------------------------------------------------------------
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  localparam int unsigned MEM_AW    = 10;
  localparam int unsigned MEM_WORDS = 1 << MEM_AW;
  // Boot at the last halfword so the first fetch wraps around memory
  localparam pc_t         BOOT_PC   = 32'h0000_07FE;
  localparam int          TIMEOUT   = 40;

  logic              clk;
  logic              rst_n;
  logic              run;
  logic              load_req;
  logic [MEM_AW-1:0] load_addr;
  half_t             load_data;
  logic              load_ack;
  logic              instr_req;
  instr_t            instr;
  pc_t               instr_pc;
  logic              instr_taken;
  logic              instr_ack;

  // Model memory image and expected fetch position
  half_t model_mem [0:MEM_WORDS-1];
  pc_t   model_pc;
  int    error_count;
  int    timeout_count;

  fetch_top #(
    .MEM_AW  (MEM_AW),
    .BOOT_PC (BOOT_PC)
  ) dut_i (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .run_i         (run),
    .load_req_i    (load_req),
    .load_addr_i   (load_addr),
    .load_data_i   (load_data),
    .load_ack_o    (load_ack),
    .instr_req_o   (instr_req),
    .instr_o       (instr),
    .instr_pc_o    (instr_pc),
    .instr_taken_o (instr_taken),
    .instr_ack_i   (instr_ack)
  );

  always #4 clk = ~clk;

  // Wait for load ack (sel 0) or offer req (sel 1) to reach a level
  task automatic wait_level(input int sel, input logic level);
    int cycles;
    cycles = 0;
    while (((sel == 0) ? load_ack : instr_req) !== level && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (((sel == 0) ? load_ack : instr_req) !== level) begin
      timeout_count++;
      $display("Timeout at %0t: %s never went to %0b", $time,
               (sel == 0) ? "load_ack_o" : "instr_req_o", level);
    end
  endtask

  // Hold for 0 to 6 cycles
  task automatic idle_random();
    int n;
    n = $urandom % 7;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // About a third of the slots get a jump or branch pattern
  task automatic build_program();
    int unsigned i;
    int unsigned kind;
    logic [31:0] word;
    i = 0;
    while (i < MEM_WORDS) begin
      kind = $urandom % 12;
      word = $urandom;
      if (kind < 2 && i < MEM_WORDS - 1) begin
        word[6:0]        = (kind == 0) ? OPCODE_JAL : OPCODE_BRANCH;
        model_mem[i]     = word[15:0];
        model_mem[i + 1] = word[31:16];
        i = i + 2;
      end else begin
        if (kind == 2) begin
          // C.J or C.JAL
          word[1:0]   = 2'b01;
          word[15:13] = word[16] ? 3'b101 : 3'b001;
        end else if (kind == 3) begin
          // C.BEQZ or C.BNEZ
          word[1:0]   = 2'b01;
          word[15:14] = 2'b11;
        end
        model_mem[i] = word[15:0];
        i = i + 1;
      end
    end
  endtask

  // One full four-phase write on the load port
  task automatic load_half(input logic [MEM_AW-1:0] addr, input half_t data);
    load_addr = addr;
    load_data = data;
    load_req  = 1'b1;
    wait_level(0, 1'b1);
    load_req  = 1'b0;
    wait_level(0, 1'b0);
  endtask

  // Static prediction from the RISC-V immediate layouts
  function automatic void predict(input instr_t w, input pc_t pc,
                                  output logic taken, output pc_t next_pc);
    pc_t  off;
    logic jump;
    logic cond;
    off  = '0;
    jump = 1'b0;
    cond = 1'b0;
    if (w[6:0] == OPCODE_JAL) begin
      jump         = 1'b1;
      off[20]      = w[31];
      off[10:1]    = w[30:21];
      off[11]      = w[20];
      off[19:12]   = w[19:12];
      off          = $signed(off << 11) >>> 11;
    end else if (w[6:0] == OPCODE_BRANCH) begin
      cond         = 1'b1;
      off[12]      = w[31];
      off[10:5]    = w[30:25];
      off[4:1]     = w[11:8];
      off[11]      = w[7];
      off          = $signed(off << 19) >>> 19;
    end else if (w[1:0] == 2'b01 && w[14:13] == 2'b01) begin
      // funct3 x01, compressed jump
      jump         = 1'b1;
      off[11]      = w[12];
      off[4]       = w[11];
      off[9:8]     = w[10:9];
      off[10]      = w[8];
      off[6]       = w[7];
      off[7]       = w[6];
      off[3:1]     = w[5:3];
      off[5]       = w[2];
      off          = $signed(off << 20) >>> 20;
    end else if (w[1:0] == 2'b01 && w[15:14] == 2'b11) begin
      cond         = 1'b1;
      off[8]       = w[12];
      off[4:3]     = w[11:10];
      off[7:6]     = w[6:5];
      off[2:1]     = w[4:3];
      off[5]       = w[2];
      off          = $signed(off << 23) >>> 23;
    end
    // Backward conditional branches only
    taken   = jump || (cond && off[31]);
    next_pc = taken ? pc + off : pc + ((w[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endfunction

  // Check one offer, then complete its handshake
  task automatic check_offer();
    int unsigned idx;
    instr_t      exp_instr;
    logic        exp_taken;
    pc_t         exp_next;
    wait_level(1, 1'b1);
    if (timeout_count != 0) begin
      return;
    end
    // Upper halfword wraps to the start of memory
    idx       = (model_pc >> 1) % MEM_WORDS;
    exp_instr = {model_mem[(idx + 1) % MEM_WORDS], model_mem[idx]};
    predict(exp_instr, model_pc, exp_taken, exp_next);
    if (instr_pc !== model_pc) begin
      error_count++;
      $display("Fail t=%0t instr_pc_o expected %h got %h", $time, model_pc, instr_pc);
    end
    if (instr !== exp_instr) begin
      error_count++;
      $display("Fail t=%0t instr_o expected %h got %h", $time, exp_instr, instr);
    end
    if (instr_taken !== exp_taken) begin
      error_count++;
      $display("Fail t=%0t instr_taken_o expected %b got %b", $time, exp_taken, instr_taken);
    end
    model_pc = exp_next;
    idle_random();
    instr_ack = 1'b1;
    wait_level(1, 1'b0);
    idle_random();
    instr_ack = 1'b0;
  endtask

  // No offer may appear while stopped
  task automatic check_stopped(input int cycles);
    int n;
    for (n = 0; n < cycles; n++) begin
      @(posedge clk);
      #1;
      if (instr_req !== 1'b0) begin
        error_count++;
        $display("Fail t=%0t instr_req_o expected 0 got %b", $time, instr_req);
      end
    end
  endtask

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    run           = 1'b0;
    load_req      = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    instr_ack     = 1'b0;
    error_count   = 0;
    timeout_count = 0;
    void'($urandom(32'h5e95));
    model_pc = BOOT_PC;
    build_program();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (instr_req !== 1'b0) begin
      error_count++;
      $display("Fail t=%0t instr_req_o expected 0 got %b", $time, instr_req);
    end
    if (load_ack !== 1'b0) begin
      error_count++;
      $display("Fail t=%0t load_ack_o expected 0 got %b", $time, load_ack);
    end
    // Program load with the controller idle
    for (int a = 0; a < MEM_WORDS && timeout_count == 0; a++) begin
      load_half(a[MEM_AW-1:0], model_mem[a]);
    end
    run = 1'b1;
    for (int k = 0; k < 400 && timeout_count == 0; k++) begin
      check_offer();
      // Stop mid run, then resume from the held PC
      if (k == 200) begin
        run = 1'b0;
        check_stopped(20);
        run = 1'b1;
      end
    end
    $display("Errors: %0d check failures, %0d timeouts, %0d assertion failures",
             error_count, timeout_count, dut_i.u_props.fail_count);
    if (error_count == 0 && timeout_count == 0 && dut_i.u_props.fail_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
common/fetch_pkg.sv
fetch/branch_predict.sv
fetch/fetch_ctrl.sv
rtl/instr_mem.sv
rtl/fetch_top.sv
testbench/fetch_props.sv
testbench/tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_top -f project.f -Mdir obj_dir -o sim_fetch
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_fetch +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
exit 0
